// ==== udp_rx_pkg.sv ====
`default_nettype none

package udp_rx_pkg;

  // widths of the data paths
  localparam int WORD_W    = 64;
  localparam int BYTE_EN_W = 8;
  localparam int MAC_W     = 48;
  localparam int IP_W      = 32;
  localparam int PORT_W    = 16;

  // one 8-byte word from the MAC or to the application
  typedef logic [WORD_W-1:0]    word_t;
  // per-byte valid flags from the MAC
  typedef logic [BYTE_EN_W-1:0] byte_en_t;

  // addresses and ports
  typedef logic [MAC_W-1:0]     mac_addr_t;
  typedef logic [IP_W-1:0]      ip_addr_t;
  typedef logic [PORT_W-1:0]    udp_port_t;

  // buffer entry layout
  // payload word sits in the low WORD_W bits
  localparam int ENTRY_LAST_BIT = WORD_W;
  localparam int ENTRY_BAD_BIT  = WORD_W + 1;
  localparam int ENTRY_OVR_BIT  = WORD_W + 2;
  // frame source address above the flags
  localparam int ENTRY_IP_LSB   = WORD_W + 3;
  localparam int ENTRY_PORT_LSB = ENTRY_IP_LSB + IP_W;
  localparam int ENTRY_W        = ENTRY_PORT_LSB + PORT_W;

  // 115 bits in total
  typedef logic [ENTRY_W-1:0] buf_entry_t;

endpackage

`default_nettype wire

// ==== frame_meta_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// per-frame verdict from the header filter
interface frame_meta_if;
  import udp_rx_pkg::*;

  logic      meta_valid;
  logic      accept;
  ip_addr_t  src_ip;
  udp_port_t src_port;

  modport filter (
    output meta_valid,
    output accept,
    output src_ip,
    output src_port
  );

  // sampled every cycle, no ready
  modport buffer (
    input meta_valid,
    input accept,
    input src_ip,
    input src_port
  );

endinterface

`default_nettype wire

// ==== payload_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// realigned payload words, one per pl_valid pulse
interface payload_if;
  import udp_rx_pkg::*;

  logic  pl_valid;
  word_t pl_data;
  logic  pl_last;
  logic  pl_bad;

  modport aligner (
    output pl_valid,
    output pl_data,
    output pl_last,
    output pl_bad
  );

  // last and bad only ever come with the final word
  modport buffer (
    input pl_valid,
    input pl_data,
    input pl_last,
    input pl_bad
  );

endinterface

`default_nettype wire

// ==== udp_header_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_header_filter (
  input  wire                   mac_clk,
  input  wire                   mac_rst,
  input  wire udp_rx_pkg::word_t    mac_rx_data,
  input  wire udp_rx_pkg::byte_en_t mac_rx_data_valid,
  input  wire                   local_enable,
  input  wire udp_rx_pkg::mac_addr_t local_mac,
  input  wire udp_rx_pkg::ip_addr_t  local_ip,
  input  wire udp_rx_pkg::udp_port_t local_port,
  input  wire udp_rx_pkg::ip_addr_t  local_mc_ip,
  input  wire udp_rx_pkg::ip_addr_t  local_mc_mask,
  frame_meta_if.filter          meta
);
  import udp_rx_pkg::*;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  VER_IHL        = 8'h45;
  localparam logic [7:0]  PROTO_UDP      = 8'h11;
  localparam logic [23:0] MC_MAC_PREFIX  = 24'h01005e;

  // one state per header word, then the rest of the frame
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HDR1,
    ST_HDR2,
    ST_HDR3,
    ST_HDR4,
    ST_HDR5,
    ST_DATA
  } state_t;

  state_t    state;
  logic      word_in;
  logic      accept_q;
  logic      mac_ok;
  logic      ip_ok;
  logic [15:0] dst_ip_hi;
  logic [15:0] ethertype;
  mac_addr_t dst_mac;
  ip_addr_t  dst_ip;
  udp_port_t dst_port;

  assign word_in = (mac_rx_data_valid == '1);

  // frame byte 0 is the low byte of the word, network order is big endian
  assign dst_mac = {mac_rx_data[7:0],   mac_rx_data[15:8],  mac_rx_data[23:16],
                    mac_rx_data[31:24], mac_rx_data[39:32], mac_rx_data[47:40]};
  assign ethertype = {mac_rx_data[39:32], mac_rx_data[47:40]};
  // dest ip straddles words 3 and 4
  assign dst_ip   = {dst_ip_hi, mac_rx_data[7:0], mac_rx_data[15:8]};
  assign dst_port = {mac_rx_data[39:32], mac_rx_data[47:40]};

  assign mac_ok = (dst_mac == local_mac) || (dst_mac == '1) ||
                  (dst_mac[47:24] == MC_MAC_PREFIX);
  assign ip_ok  = (dst_ip == local_ip) || (dst_ip == local_mc_ip) ||
                  ((dst_ip & local_mc_mask) == (local_mc_ip & local_mc_mask));

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state           <= ST_IDLE;
      accept_q        <= 1'b0;
      meta.meta_valid <= 1'b0;
      meta.accept     <= 1'b0;
    end else begin
      meta.meta_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (word_in) begin
            accept_q <= mac_ok;
            state    <= ST_HDR1;
          end
        end
        ST_HDR1: begin
          if (ethertype != ETHERTYPE_IPV4 || mac_rx_data[55:48] != VER_IHL) begin
            accept_q <= 1'b0;
          end
          state <= word_in ? ST_HDR2 : ST_IDLE;
        end
        ST_HDR2: begin
          if (mac_rx_data[63:56] != PROTO_UDP) begin
            accept_q <= 1'b0;
          end
          state <= word_in ? ST_HDR3 : ST_IDLE;
        end
        ST_HDR3: begin
          state <= word_in ? ST_HDR4 : ST_IDLE;
        end
        ST_HDR4: begin
          if (!ip_ok || dst_port != local_port) begin
            accept_q <= 1'b0;
          end
          state <= word_in ? ST_HDR5 : ST_IDLE;
        end
        ST_HDR5: begin
          // udp length and checksum are not checked
          if (word_in) begin
            meta.meta_valid <= 1'b1;
            meta.accept     <= accept_q && local_enable;
            state           <= ST_DATA;
          end else begin
            state <= ST_IDLE;
          end
        end
        ST_DATA: begin
          // gap after the last word ends the frame
          if (!word_in) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // source address and upper half of dest ip
  always_ff @(posedge mac_clk) begin
    if (state == ST_HDR3) begin
      meta.src_ip <= {mac_rx_data[23:16], mac_rx_data[31:24],
                      mac_rx_data[39:32], mac_rx_data[47:40]};
      dst_ip_hi   <= {mac_rx_data[55:48], mac_rx_data[63:56]};
    end
    if (state == ST_HDR4) begin
      meta.src_port <= {mac_rx_data[23:16], mac_rx_data[31:24]};
    end
  end

  a_meta_after_hdr5: assert property (@(posedge mac_clk) disable iff (mac_rst)
    meta.meta_valid |-> ($past(state) == ST_HDR5) && (state == ST_DATA))
    else $error("meta_valid outside the step from header word 5");

endmodule

`default_nettype wire

// ==== payload_aligner.sv ====
`timescale 1ns/100ps
`default_nettype none

module payload_aligner (
  input  wire                       mac_clk,
  input  wire                       mac_rst,
  input  wire udp_rx_pkg::word_t    mac_rx_data,
  input  wire udp_rx_pkg::byte_en_t mac_rx_data_valid,
  input  wire                       mac_rx_good_frame,
  input  wire                       mac_rx_bad_frame,
  payload_if.aligner                pl
);
  import udp_rx_pkg::*;

  // payload starts in the 6th word, byte 42 = word 5 byte 2
  localparam logic [2:0] PL_START = 3'd6;

  logic       word_in;
  logic       frame_end;
  logic [2:0] word_cnt;
  logic       pend_valid;
  word_t      prev_word;
  word_t      pend_data;
  word_t      joined;

  assign word_in   = (mac_rx_data_valid == '1);
  assign frame_end = mac_rx_good_frame || mac_rx_bad_frame;

  // last 6 bytes of the previous word, first 2 of this one
  // earliest byte ends up in the top byte
  assign joined = {prev_word[23:16], prev_word[31:24], prev_word[39:32],
                   prev_word[47:40], prev_word[55:48], prev_word[63:56],
                   mac_rx_data[7:0], mac_rx_data[15:8]};

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      word_cnt    <= '0;
      pend_valid  <= 1'b0;
      pl.pl_valid <= 1'b0;
      pl.pl_last  <= 1'b0;
      pl.pl_bad   <= 1'b0;
    end else begin
      pl.pl_valid <= 1'b0;
      pl.pl_last  <= 1'b0;
      pl.pl_bad   <= 1'b0;
      if (word_in) begin
        if (word_cnt != PL_START) begin
          word_cnt <= word_cnt + 3'd1;
        end else begin
          // a newer word follows, so the held one is not the last
          pl.pl_valid <= pend_valid;
          pend_valid  <= 1'b1;
        end
      end else if (frame_end) begin
        word_cnt    <= '0;
        pend_valid  <= 1'b0;
        pl.pl_valid <= pend_valid;
        pl.pl_last  <= pend_valid;
        pl.pl_bad   <= pend_valid && mac_rx_bad_frame;
      end
    end
  end

  always_ff @(posedge mac_clk) begin
    if (word_in) begin
      prev_word <= mac_rx_data;
      if (word_cnt == PL_START) begin
        pend_data <= joined;
      end
    end
    if (word_in || frame_end) begin
      pl.pl_data <= pend_data;
    end
  end

  a_last_with_valid: assert property (@(posedge mac_clk) disable iff (mac_rst)
    pl.pl_last |-> pl.pl_valid && $past(frame_end))
    else $error("pl_last without pl_valid or end strobe");

endmodule

`default_nettype wire

// ==== rx_frame_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_frame_buffer #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  wire                        mac_clk,
  input  wire                        mac_rst,
  frame_meta_if.buffer               meta,
  payload_if.buffer                  pl,
  input  wire                        app_ready,
  output logic                       app_valid,
  output udp_rx_pkg::word_t          app_data,
  output logic                       app_last,
  output logic                       app_bad,
  output logic                       app_overrun,
  output udp_rx_pkg::ip_addr_t       app_src_ip,
  output udp_rx_pkg::udp_port_t      app_src_port
);
  import udp_rx_pkg::*;

  localparam int unsigned AW = $clog2(FIFO_DEPTH);

  typedef logic [AW:0] cnt_t;

  localparam cnt_t FULL_CNT = cnt_t'(FIFO_DEPTH);
  localparam cnt_t NEAR_CNT = cnt_t'(FIFO_DEPTH - 1);

  if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
    $error("FIFO_DEPTH must be a power of two");
  end

  buf_entry_t      mem [FIFO_DEPTH];
  buf_entry_t      wr_entry;
  buf_entry_t      rd_entry;
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  cnt_t            count;
  logic            armed;
  logic            full;
  logic            near_full;
  logic            wr_en;
  logic            rd_en;
  ip_addr_t        frame_ip;
  udp_port_t       frame_port;

  assign full      = (count == FULL_CNT);
  assign near_full = (count == NEAR_CNT);
  assign wr_en     = pl.pl_valid && armed;
  assign rd_en     = app_valid && app_ready;

  // word written at near full closes the frame as an overrun
  always_comb begin
    wr_entry                                 = '0;
    wr_entry[WORD_W-1:0]                     = pl.pl_data;
    wr_entry[ENTRY_LAST_BIT]                 = pl.pl_last || near_full;
    wr_entry[ENTRY_BAD_BIT]                  = pl.pl_bad;
    wr_entry[ENTRY_OVR_BIT]                  = near_full;
    wr_entry[ENTRY_IP_LSB +: IP_W]           = frame_ip;
    wr_entry[ENTRY_PORT_LSB +: PORT_W]       = frame_port;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      armed  <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (wr_en && (pl.pl_last || near_full)) begin
        armed <= 1'b0;
      end
      // no room for even the first word, so the whole frame is dropped
      if (meta.meta_valid) begin
        armed <= meta.accept && !full;
      end
    end
  end

  always_ff @(posedge mac_clk) begin
    if (meta.meta_valid) begin
      frame_ip   <= meta.src_ip;
      frame_port <= meta.src_port;
    end
    if (wr_en) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  assign rd_entry     = mem[rd_ptr];
  assign app_valid    = (count != '0);
  assign app_data     = rd_entry[WORD_W-1:0];
  assign app_last     = rd_entry[ENTRY_LAST_BIT];
  assign app_bad      = rd_entry[ENTRY_BAD_BIT];
  assign app_overrun  = rd_entry[ENTRY_OVR_BIT];
  assign app_src_ip   = rd_entry[ENTRY_IP_LSB +: IP_W];
  assign app_src_port = rd_entry[ENTRY_PORT_LSB +: PORT_W];

  a_no_write_full: assert property (@(posedge mac_clk) disable iff (mac_rst)
    wr_en |-> !full)
    else $error("buffer written while full");

  a_hold_stalled: assert property (@(posedge mac_clk) disable iff (mac_rst)
    (app_valid && !app_ready) |=> (app_valid && $stable(rd_entry)))
    else $error("output entry changed under back-pressure");

endmodule

`default_nettype wire

// ==== udp_rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module udp_rx_top #(
  parameter int unsigned FIFO_DEPTH = 16
) (
  input  wire                        mac_clk,
  input  wire                        mac_rst,
  input  wire udp_rx_pkg::word_t     mac_rx_data,
  input  wire udp_rx_pkg::byte_en_t  mac_rx_data_valid,
  input  wire                        mac_rx_good_frame,
  input  wire                        mac_rx_bad_frame,
  input  wire                        local_enable,
  input  wire udp_rx_pkg::mac_addr_t local_mac,
  input  wire udp_rx_pkg::ip_addr_t  local_ip,
  input  wire udp_rx_pkg::udp_port_t local_port,
  input  wire udp_rx_pkg::ip_addr_t  local_mc_ip,
  input  wire udp_rx_pkg::ip_addr_t  local_mc_mask,
  input  wire                        app_ready,
  output logic                       app_valid,
  output udp_rx_pkg::word_t          app_data,
  output logic                       app_last,
  output logic                       app_bad,
  output logic                       app_overrun,
  output udp_rx_pkg::ip_addr_t       app_src_ip,
  output udp_rx_pkg::udp_port_t      app_src_port
);

  frame_meta_if u_meta_if ();
  payload_if    u_pl_if ();

  // header checks run alongside the payload realignment
  udp_header_filter u_filter (
    .mac_clk           (mac_clk),
    .mac_rst           (mac_rst),
    .mac_rx_data       (mac_rx_data),
    .mac_rx_data_valid (mac_rx_data_valid),
    .local_enable      (local_enable),
    .local_mac         (local_mac),
    .local_ip          (local_ip),
    .local_port        (local_port),
    .local_mc_ip       (local_mc_ip),
    .local_mc_mask     (local_mc_mask),
    .meta              (u_meta_if.filter)
  );

  payload_aligner u_aligner (
    .mac_clk           (mac_clk),
    .mac_rst           (mac_rst),
    .mac_rx_data       (mac_rx_data),
    .mac_rx_data_valid (mac_rx_data_valid),
    .mac_rx_good_frame (mac_rx_good_frame),
    .mac_rx_bad_frame  (mac_rx_bad_frame),
    .pl                (u_pl_if.aligner)
  );

  rx_frame_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_buffer (
    .mac_clk      (mac_clk),
    .mac_rst      (mac_rst),
    .meta         (u_meta_if.buffer),
    .pl           (u_pl_if.buffer),
    .app_ready    (app_ready),
    .app_valid    (app_valid),
    .app_data     (app_data),
    .app_last     (app_last),
    .app_bad      (app_bad),
    .app_overrun  (app_overrun),
    .app_src_ip   (app_src_ip),
    .app_src_port (app_src_port)
  );

endmodule

`default_nettype wire

// ==== tb_udp_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_udp_rx;
  import udp_rx_pkg::*;

  localparam int FIFO_DEPTH   = 16;
  localparam int CLK_PERIOD   = 40;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_ROWS     = 18;
  localparam int MAX_BYTES    = 256;
  localparam int DRAIN_LIMIT  = 200;

  localparam mac_addr_t LOC_MAC  = 48'h02_12_34_56_78_9a;
  localparam ip_addr_t  LOC_IP   = 32'h0a00_0002;
  localparam udp_port_t LOC_PORT = 16'h1388;
  localparam ip_addr_t  MC_IP    = 32'hef01_0203;
  localparam ip_addr_t  MC_MASK  = 32'hffff_ff00;

  typedef enum logic [1:0] {
    RDY_ALWAYS,
    RDY_RANDOM,
    RDY_HELD
  } ready_mode_t;

  // one frame of stimulus with its expected verdict
  typedef struct packed {
    mac_addr_t   dst_mac;
    logic [15:0] ethertype;
    logic [7:0]  ver_ihl;
    logic [7:0]  proto;
    ip_addr_t    dst_ip;
    udp_port_t   dst_port;
    ip_addr_t    src_ip;
    udp_port_t   src_port;
    logic [7:0]  n_words;
    logic        bad_end;
    logic        enable;
    ready_mode_t ready_mode;
    logic        exp_accept;
  } frame_row_t;

  typedef struct packed {
    word_t     data;
    logic      last;
    logic      bad;
    logic      ovr;
    ip_addr_t  ip;
    udp_port_t port;
  } exp_entry_t;

  logic      mac_clk;
  logic      mac_rst;
  word_t     mac_rx_data;
  byte_en_t  mac_rx_data_valid;
  logic      mac_rx_good_frame;
  logic      mac_rx_bad_frame;
  logic      local_enable;
  mac_addr_t local_mac;
  ip_addr_t  local_ip;
  udp_port_t local_port;
  ip_addr_t  local_mc_ip;
  ip_addr_t  local_mc_mask;
  logic      app_ready;
  logic      app_valid;
  word_t     app_data;
  logic      app_last;
  logic      app_bad;
  logic      app_overrun;
  ip_addr_t  app_src_ip;
  udp_port_t app_src_port;

  frame_row_t  rows [NUM_ROWS];
  string       row_names [NUM_ROWS];
  logic [7:0]  fbytes [MAX_BYTES];
  exp_entry_t  exp_q [$];
  exp_entry_t  mon_entry;
  ready_mode_t ready_mode;
  string       cur_name;
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  logic        table_ready;
  longint      watchdog_ns;

  udp_rx_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_udp_rx_top (
    .mac_clk           (mac_clk),
    .mac_rst           (mac_rst),
    .mac_rx_data       (mac_rx_data),
    .mac_rx_data_valid (mac_rx_data_valid),
    .mac_rx_good_frame (mac_rx_good_frame),
    .mac_rx_bad_frame  (mac_rx_bad_frame),
    .local_enable      (local_enable),
    .local_mac         (local_mac),
    .local_ip          (local_ip),
    .local_port        (local_port),
    .local_mc_ip       (local_mc_ip),
    .local_mc_mask     (local_mc_mask),
    .app_ready         (app_ready),
    .app_valid         (app_valid),
    .app_data          (app_data),
    .app_last          (app_last),
    .app_bad           (app_bad),
    .app_overrun       (app_overrun),
    .app_src_ip        (app_src_ip),
    .app_src_port      (app_src_port)
  );

  initial begin
    mac_clk = 1'b0;
    forever #(CLK_PERIOD / 2) mac_clk = ~mac_clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // writes a field in network byte order
  function automatic void put_field(input int pos, input int len, input logic [47:0] val);
    for (int j = 0; j < len; j++) begin
      fbytes[pos + j] = val[8 * (len - 1 - j) +: 8];
    end
  endfunction

  task automatic build_table();
    row_names[0] = "unicast";
    rows[0] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                32'hc0a8_0001, 16'h4000, 8'd5, 1'b0, 1'b1, RDY_ALWAYS, 1'b1};
    row_names[1] = "wrong_mac";
    rows[1] = '{48'h02_12_34_56_78_9b, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                32'hc0a8_0002, 16'h4001, 8'd2, 1'b0, 1'b1, RDY_ALWAYS, 1'b0};
    row_names[2] = "wrong_ethertype";
    rows[2] = '{LOC_MAC, 16'h86dd, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                32'hc0a8_0003, 16'h4002, 8'd2, 1'b0, 1'b1, RDY_ALWAYS, 1'b0};
    row_names[3] = "bad_ver_ihl";
    rows[3] = '{LOC_MAC, 16'h0800, 8'h46, 8'h11, LOC_IP, LOC_PORT,
                32'hc0a8_0004, 16'h4003, 8'd2, 1'b0, 1'b1, RDY_ALWAYS, 1'b0};
    row_names[4] = "not_udp";
    rows[4] = '{LOC_MAC, 16'h0800, 8'h45, 8'h06, LOC_IP, LOC_PORT,
                32'hc0a8_0005, 16'h4004, 8'd2, 1'b0, 1'b1, RDY_ALWAYS, 1'b0};
    row_names[5] = "wrong_port";
    rows[5] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, LOC_IP, 16'h1389,
                32'hc0a8_0006, 16'h4005, 8'd2, 1'b0, 1'b1, RDY_ALWAYS, 1'b0};
    row_names[6] = "wrong_ip";
    rows[6] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, 32'h0a00_0009, LOC_PORT,
                32'hc0a8_0007, 16'h4006, 8'd2, 1'b0, 1'b1, RDY_ALWAYS, 1'b0};
    row_names[7] = "disabled";
    rows[7] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                32'hc0a8_0008, 16'h4007, 8'd2, 1'b0, 1'b0, RDY_ALWAYS, 1'b0};
    row_names[8] = "broadcast";
    rows[8] = '{48'hff_ff_ff_ff_ff_ff, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                32'hc0a8_0009, 16'h4008, 8'd3, 1'b0, 1'b1, RDY_ALWAYS, 1'b1};
    row_names[9] = "mc_mac";
    rows[9] = '{48'h01_00_5e_01_02_03, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                32'hc0a8_000a, 16'h4009, 8'd2, 1'b0, 1'b1, RDY_ALWAYS, 1'b1};
    row_names[10] = "mc_ip_exact";
    rows[10] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, MC_IP, LOC_PORT,
                 32'hc0a8_000b, 16'h400a, 8'd2, 1'b0, 1'b1, RDY_ALWAYS, 1'b1};
    row_names[11] = "mc_ip_masked";
    rows[11] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, 32'hef01_02a7, LOC_PORT,
                 32'hc0a8_000c, 16'h400b, 8'd3, 1'b0, 1'b1, RDY_ALWAYS, 1'b1};
    row_names[12] = "bad_end";
    rows[12] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                 32'hc0a8_000d, 16'h400c, 8'd4, 1'b1, 1'b1, RDY_ALWAYS, 1'b1};
    row_names[13] = "random_ready";
    rows[13] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                 32'hc0a8_000e, 16'h400d, 8'd12, 1'b0, 1'b1, RDY_RANDOM, 1'b1};
    row_names[14] = "random_ready_bad";
    rows[14] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                 32'hc0a8_000f, 16'h400e, 8'd1, 1'b1, 1'b1, RDY_RANDOM, 1'b1};
    row_names[15] = "overrun_held";
    rows[15] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                 32'hc0a8_0010, 16'h400f, 8'd20, 1'b0, 1'b1, RDY_HELD, 1'b1};
    row_names[16] = "after_overrun";
    rows[16] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                 32'hc0a8_0011, 16'h4010, 8'd7, 1'b0, 1'b1, RDY_ALWAYS, 1'b1};
    row_names[17] = "single_word";
    rows[17] = '{LOC_MAC, 16'h0800, 8'h45, 8'h11, LOC_IP, LOC_PORT,
                 32'hc0a8_0012, 16'h4011, 8'd1, 1'b0, 1'b1, RDY_ALWAYS, 1'b1};
  endtask

  // random bytes everywhere, then the checked header fields on top
  task automatic build_frame(input int r);
    int n_bytes;
    n_bytes = (int'(rows[r].n_words) + 6) * 8;
    for (int i = 0; i < n_bytes; i++) begin
      rng_state = xorshift32(rng_state);
      fbytes[i] = rng_state[7:0];
    end
    put_field(0, 6, rows[r].dst_mac);
    put_field(12, 2, 48'(rows[r].ethertype));
    put_field(14, 1, 48'(rows[r].ver_ihl));
    put_field(23, 1, 48'(rows[r].proto));
    put_field(26, 4, 48'(rows[r].src_ip));
    put_field(30, 4, 48'(rows[r].dst_ip));
    put_field(34, 2, 48'(rows[r].src_port));
    put_field(36, 2, 48'(rows[r].dst_port));
  endtask

  // reference model, payload word k is bytes 42+8k to 49+8k
  task automatic expect_frame(input int r);
    exp_entry_t e;
    int         n_words;
    int         n_keep;
    logic       ovr;
    n_words = int'(rows[r].n_words);
    n_keep  = n_words;
    ovr     = 1'b0;
    // with ready held low the buffer fills and the frame is cut
    if (rows[r].ready_mode == RDY_HELD && n_words >= FIFO_DEPTH) begin
      n_keep = FIFO_DEPTH;
      ovr    = 1'b1;
    end
    for (int k = 0; k < n_keep; k++) begin
      e.data = '0;
      for (int j = 0; j < 8; j++) begin
        e.data = {e.data[55:0], fbytes[42 + 8 * k + j]};
      end
      e.last = (k == n_keep - 1);
      e.bad  = (k == n_words - 1) && rows[r].bad_end;
      e.ovr  = ovr && (k == n_keep - 1);
      e.ip   = rows[r].src_ip;
      e.port = rows[r].src_port;
      exp_q.push_back(e);
    end
  endtask

  task automatic step_cycle();
    @(posedge mac_clk);
    #(DRIVE_DELAY);
    case (ready_mode)
      RDY_ALWAYS: app_ready = 1'b1;
      RDY_RANDOM: begin
        rng_state = xorshift32(rng_state);
        app_ready = rng_state[0];
      end
      default: app_ready = 1'b0;
    endcase
  endtask

  task automatic drive_frame(input int r);
    int n_in;
    n_in = int'(rows[r].n_words) + 6;
    for (int i = 0; i < n_in; i++) begin
      for (int j = 0; j < 8; j++) begin
        mac_rx_data[8 * j +: 8] = fbytes[8 * i + j];
      end
      mac_rx_data_valid = 8'hff;
      step_cycle();
    end
    mac_rx_data       = '0;
    mac_rx_data_valid = '0;
    if (rows[r].bad_end) begin
      mac_rx_bad_frame = 1'b1;
    end else begin
      mac_rx_good_frame = 1'b1;
    end
    step_cycle();
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
    step_cycle();
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() > 0 && cycles < DRAIN_LIMIT) begin
      step_cycle();
      cycles++;
    end
    assert (exp_q.size() == 0) else begin
      $display("%s: %0d expected words never came out", cur_name, exp_q.size());
      errors++;
      exp_q.delete();
    end
    // room for stray words to show up
    repeat (4) step_cycle();
  endtask

  task automatic check_value(input string field, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("Error %s %s: expected %h, actual %h", cur_name, field, expected, actual);
      errors++;
    end
  endtask

  // outputs settle after the rising edge, so look at them half a cycle later
  always @(negedge mac_clk) begin
    if (!mac_rst && app_valid && app_ready) begin
      assert (exp_q.size() > 0) else begin
        $display("%s: output word %h came out with none expected", cur_name, app_data);
        errors++;
      end
      if (exp_q.size() > 0) begin
        mon_entry = exp_q.pop_front();
        check_value("data", mon_entry.data, app_data);
        check_value("last", 64'(mon_entry.last), 64'(app_last));
        check_value("bad", 64'(mon_entry.bad), 64'(app_bad));
        check_value("overrun", 64'(mon_entry.ovr), 64'(app_overrun));
        check_value("src_ip", 64'(mon_entry.ip), 64'(app_src_ip));
        check_value("src_port", 64'(mon_entry.port), 64'(app_src_port));
      end
    end
  end

  initial begin
    wait (table_ready);
    #(watchdog_ns);
    $display("watchdog expired before all frames were done");
    $display("Something failed");
    $finish;
  end

  initial begin
    mac_rst           = 1'b1;
    mac_rx_data       = '0;
    mac_rx_data_valid = '0;
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
    local_enable      = 1'b0;
    local_mac         = LOC_MAC;
    local_ip          = LOC_IP;
    local_port        = LOC_PORT;
    local_mc_ip       = MC_IP;
    local_mc_mask     = MC_MASK;
    app_ready         = 1'b0;
    ready_mode        = RDY_ALWAYS;
    rng_state         = 32'h41eb;
    errors            = 0;
    checks            = 0;
    cur_name          = "reset";
    table_ready       = 1'b0;
    watchdog_ns       = 0;
    build_table();
    // four cycles per input word, plus the reset
    for (int r = 0; r < NUM_ROWS; r++) begin
      watchdog_ns += longint'(int'(rows[r].n_words) + 6) * 4 * CLK_PERIOD;
    end
    watchdog_ns += longint'(RESET_CYCLES) * CLK_PERIOD;
    table_ready = 1'b1;
    repeat (RESET_CYCLES) step_cycle();
    mac_rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_name     = row_names[r];
      local_enable = rows[r].enable;
      ready_mode   = rows[r].ready_mode;
      build_frame(r);
      if (rows[r].exp_accept) begin
        expect_frame(r);
      end
      drive_frame(r);
      if (ready_mode == RDY_HELD) begin
        repeat (4) step_cycle();
        ready_mode = RDY_ALWAYS;
      end
      wait_drain();
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== udp_rx.f ====
udp_rx_pkg.sv
frame_meta_if.sv
payload_if.sv
udp_header_filter.sv
payload_aligner.sv
rx_frame_buffer.sv
udp_rx_top.sv
tb_udp_rx.sv

// ==== Makefile ====
TOP := tb_udp_rx

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f udp_rx.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f udp_rx.f \
		--top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; exit $$rc
	@if grep -q "Something failed" sim.log; then \
		echo "simulation reported a failure"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
